//--- include/frontend_params.svh
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// first fetch address after reset
`define FE_RESET_PC     32'h1c000000

// queue depths, kept to powers of two
`define FE_FETCH_DEPTH  8
`define FE_DECODE_DEPTH 4

`define FE_PC_WIDTH     32
`define FE_INST_WIDTH   32
`define FE_REG_WIDTH    5

// opcode field is inst[31:26]
`define FE_OP_ALU       6'd0
`define FE_OP_IMM_LO    6'd1
`define FE_OP_IMM_HI    6'd15
`define FE_OP_B         6'd20
`define FE_OP_BL        6'd21
`define FE_OP_BR_LO     6'd22
`define FE_OP_BR_HI     6'd27

`endif

//--- src/frontend_pkg.sv
`include "frontend_params.svh"

package frontend_pkg;

    // byte address of an instruction
    typedef logic [`FE_PC_WIDTH-1:0] pc_t;

    // raw instruction word as fetched
    typedef logic [`FE_INST_WIDTH-1:0] inst_word_t;

    // architectural register index
    typedef logic [`FE_REG_WIDTH-1:0] reg_idx_t;

    // one request in flight at most
    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_e;

endpackage

//--- src/pc_gen.sv
`timescale 1ns/1ps
`include "frontend_params.svh"

module pc_gen (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               take_i,
    input  logic               redirect_i,
    input  frontend_pkg::pc_t  redirect_pc_i,
    input  logic               wait_i,
    input  logic               int_i,
    output frontend_pkg::pc_t  pc_o,
    output logic               locked_o
);
    import frontend_pkg::*;

    pc_t  pc_q;
    pc_t  pc_next_pair;
    logic lock_q;

    // next aligned pair, drops the odd-word offset after a redirect
    assign pc_next_pair = {pc_q[31:3] + 29'd1, 3'b000};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= `FE_RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (take_i) begin
            pc_q <= pc_next_pair;
        end
    end

    // idle lock, an interrupt in the same cycle wins over wait
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lock_q <= 1'b0;
        end else if (wait_i && !int_i) begin
            lock_q <= 1'b1;
        end else if (int_i) begin
            lock_q <= 1'b0;
        end
    end

    assign pc_o     = pc_q;
    assign locked_o = lock_q;

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  frontend_pkg::pc_t              pc_i,
    input  logic                           locked_i,
    input  logic                           redirect_i,
    input  logic [3:0]                     fifo_free_i,
    output logic                           take_o,
    output logic                           imem_req_o,
    output frontend_pkg::pc_t              imem_addr_o,
    input  logic                           imem_resp_valid_i,
    input  logic [63:0]                    imem_resp_data_i,
    output logic [1:0]                     wr_num_o,
    output frontend_pkg::inst_word_t [1:0] wr_word_o,
    output frontend_pkg::pc_t [1:0]        wr_pc_o
);
    import frontend_pkg::*;

    fetch_state_e state_q;
    logic         req_q;
    logic         discard_q;
    pc_t          req_pc_q;
    logic         issue;
    logic         keep;

    // two free entries guarantee room for the whole pair on return
    assign issue = (state_q == FETCH_IDLE) && !locked_i && !redirect_i
                   && (fifo_free_i >= 4'd2);
    assign take_o = issue;

    // a response caught by a redirect is dropped
    assign keep = (state_q == FETCH_WAIT) && imem_resp_valid_i
                  && !discard_q && !redirect_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= FETCH_IDLE;
            req_q     <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            req_q <= issue;
            case (state_q)
                FETCH_IDLE: begin
                    if (issue) begin
                        state_q <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (imem_resp_valid_i) begin
                        state_q   <= FETCH_IDLE;
                        discard_q <= 1'b0;
                    end else if (redirect_i) begin
                        discard_q <= 1'b1;
                    end
                end
                default: state_q <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc_q <= pc_i;
        end
    end

    // bus sees only the aligned pair address
    assign imem_req_o  = req_q;
    assign imem_addr_o = {req_pc_q[31:3], 3'b000};

    always_comb begin
        wr_word_o[1] = imem_resp_data_i[63:32];
        wr_pc_o[1]   = {req_pc_q[31:3], 3'b100};
        wr_pc_o[0]   = req_pc_q;
        if (req_pc_q[2]) begin
            // odd word entry, only the upper word belongs to the stream
            wr_word_o[0] = imem_resp_data_i[63:32];
            wr_num_o     = keep ? 2'd1 : 2'd0;
        end else begin
            wr_word_o[0] = imem_resp_data_i[31:0];
            wr_num_o     = keep ? 2'd2 : 2'd0;
        end
    end

endmodule

//--- src/multi_channel_fifo.sv
`timescale 1ns/1ps

module multi_channel_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush_i,
    input  logic [1:0]                 write_num_i,
    input  logic [1:0][DATA_WIDTH-1:0] write_data_i,
    output logic [$clog2(DEPTH):0]     free_o,
    output logic [1:0]                 read_valid_o,
    input  logic [1:0]                 read_num_i,
    output logic [1:0][DATA_WIDTH-1:0] read_data_o
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [DATA_WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]      head_q;
    logic [PTR_W-1:0]      tail_q;
    logic [PTR_W-1:0]      head_nxt;
    logic [PTR_W-1:0]      tail_nxt;
    logic [CNT_W-1:0]      count_q;
    logic [1:0]            pop_num;
    logic [1:0]            avail_num;

    // pointers wrap on their own since depth is a power of two
    assign head_nxt = head_q + 1'b1;
    assign tail_nxt = tail_q + 1'b1;

    // never pop more than the valid slots show
    assign avail_num = {read_valid_o[1], read_valid_o[0] & ~read_valid_o[1]};
    assign pop_num   = (read_num_i < avail_num) ? read_num_i : avail_num;

    // slot 1 is valid only together with slot 0
    assign read_valid_o = {count_q >= CNT_W'(2), count_q != '0};
    assign read_data_o[0] = mem_q[head_q];
    assign read_data_o[1] = mem_q[head_nxt];

    assign free_o = CNT_W'(DEPTH) - count_q;

    always_ff @(posedge clk) begin
        if (write_num_i != 2'd0) begin
            mem_q[tail_q] <= write_data_i[0];
        end
        if (write_num_i[1]) begin
            mem_q[tail_nxt] <= write_data_i[1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // flush also drops this cycle's writes
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + PTR_W'(pop_num);
            tail_q  <= tail_q + PTR_W'(write_num_i);
            count_q <= count_q + CNT_W'(write_num_i) - CNT_W'(pop_num);
        end
    end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/1ps
`include "frontend_params.svh"

module inst_decoder (
    input  frontend_pkg::inst_word_t inst_i,
    output frontend_pkg::reg_idx_t   rj_o,
    output frontend_pkg::reg_idx_t   rk_o,
    output frontend_pkg::reg_idx_t   rd_o
);
    import frontend_pkg::*;

    logic [5:0] opcode;
    reg_idx_t   fld_rd;
    reg_idx_t   fld_rj;
    reg_idx_t   fld_rk;

    assign opcode = inst_i[31:26];
    assign fld_rd = inst_i[4:0];
    assign fld_rj = inst_i[9:5];
    assign fld_rk = inst_i[14:10];

    always_comb begin
        rj_o = '0;
        rk_o = '0;
        rd_o = '0;
        if (opcode == `FE_OP_ALU) begin
            // three register form
            rk_o = fld_rk;
            rj_o = fld_rj;
            rd_o = fld_rd;
        end else if (opcode >= `FE_OP_IMM_LO && opcode <= `FE_OP_IMM_HI) begin
            rj_o = fld_rj;
            rd_o = fld_rd;
        end else if (opcode == `FE_OP_BL) begin
            // link register is r1
            rd_o = 5'd1;
        end else if (opcode >= `FE_OP_BR_LO && opcode <= `FE_OP_BR_HI) begin
            // rd field is a second source for compare branches
            rk_o = fld_rd;
            rj_o = fld_rj;
        end
    end

endmodule

//--- src/frontend.sv
`timescale 1ns/1ps
`include "frontend_params.svh"

module frontend (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic                           imem_req_o,
    output frontend_pkg::pc_t              imem_addr_o,
    input  logic                           imem_resp_valid_i,
    input  logic [63:0]                    imem_resp_data_i,
    input  logic                           redirect_i,
    input  frontend_pkg::pc_t              redirect_pc_i,
    input  logic                           wait_i,
    input  logic                           int_i,
    input  logic                           backend_stall_i,
    input  logic [1:0]                     issue_num_i,
    output logic [1:0]                     inst_valid_o,
    output frontend_pkg::pc_t [1:0]        inst_pc_o,
    output frontend_pkg::inst_word_t [1:0] inst_word_o,
    output frontend_pkg::reg_idx_t [1:0]   inst_rj_o,
    output frontend_pkg::reg_idx_t [1:0]   inst_rk_o,
    output frontend_pkg::reg_idx_t [1:0]   inst_rd_o
);
    import frontend_pkg::*;

    localparam int FETCH_W = $bits(pc_t) + $bits(inst_word_t);
    localparam int DEC_W   = FETCH_W + 3 * $bits(reg_idx_t);

    pc_t                                fetch_pc;
    logic                               locked;
    logic                               take;
    logic [$clog2(`FE_FETCH_DEPTH):0]   fetch_free;
    logic [$clog2(`FE_DECODE_DEPTH):0]  dec_free;
    logic [1:0]                         wr_num;
    inst_word_t [1:0]                   wr_word;
    pc_t [1:0]                          wr_pc;
    logic [1:0][FETCH_W-1:0]            fetch_wr_data;
    logic [1:0][FETCH_W-1:0]            fetch_rd_data;
    logic [1:0]                         fetch_valid;
    logic [1:0]                         fetch_avail;
    logic [1:0]                         xfer_num;
    logic [1:0][DEC_W-1:0]              dec_wr_data;
    logic [1:0][DEC_W-1:0]              dec_rd_data;
    logic [1:0]                         pop_num;
    reg_idx_t [1:0]                     dec_rj;
    reg_idx_t [1:0]                     dec_rk;
    reg_idx_t [1:0]                     dec_rd;

    pc_gen u_pc_gen (
        .clk, .rst_n,
        .take_i(take), .redirect_i, .redirect_pc_i,
        .wait_i, .int_i,
        .pc_o(fetch_pc), .locked_o(locked)
    );

    fetch_unit u_fetch_unit (
        .clk, .rst_n,
        .pc_i(fetch_pc), .locked_i(locked), .redirect_i,
        .fifo_free_i(fetch_free), .take_o(take),
        .imem_req_o, .imem_addr_o, .imem_resp_valid_i, .imem_resp_data_i,
        .wr_num_o(wr_num), .wr_word_o(wr_word), .wr_pc_o(wr_pc)
    );

    multi_channel_fifo #(.DATA_WIDTH(FETCH_W), .DEPTH(`FE_FETCH_DEPTH)) fetch_fifo (
        .clk, .rst_n, .flush_i(redirect_i),
        .write_num_i(wr_num), .write_data_i(fetch_wr_data), .free_o(fetch_free),
        .read_valid_o(fetch_valid), .read_num_i(xfer_num), .read_data_o(fetch_rd_data)
    );

    // move as much as the fetch queue offers and the decoded queue can hold
    assign fetch_avail = {fetch_valid[1], fetch_valid[0] & ~fetch_valid[1]};
    assign xfer_num = (dec_free >= 3'(fetch_avail)) ? fetch_avail : dec_free[1:0];

    for (genvar i = 0; i < 2; i++) begin : g_lane
        assign fetch_wr_data[i] = {wr_pc[i], wr_word[i]};

        // decode sits between the two queues
        inst_decoder u_decoder (
            .inst_i(fetch_rd_data[i][$bits(inst_word_t)-1:0]),
            .rj_o(dec_rj[i]), .rk_o(dec_rk[i]), .rd_o(dec_rd[i])
        );

        assign dec_wr_data[i] = {fetch_rd_data[i], dec_rj[i], dec_rk[i], dec_rd[i]};
        assign {inst_pc_o[i], inst_word_o[i], inst_rj_o[i], inst_rk_o[i], inst_rd_o[i]}
            = dec_rd_data[i];
    end

    // the queue clips the pop to what it holds
    assign pop_num = backend_stall_i ? 2'd0 : issue_num_i;

    multi_channel_fifo #(.DATA_WIDTH(DEC_W), .DEPTH(`FE_DECODE_DEPTH)) decoded_fifo (
        .clk, .rst_n, .flush_i(redirect_i),
        .write_num_i(xfer_num), .write_data_i(dec_wr_data), .free_o(dec_free),
        .read_valid_o(inst_valid_o), .read_num_i(pop_num), .read_data_o(dec_rd_data)
    );

endmodule

//--- test/frontend_assert.sv
`timescale 1ns/1ps

module frontend_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              imem_req_i,
    input frontend_pkg::pc_t imem_addr_i,
    input logic              imem_resp_valid_i,
    input logic [1:0]        inst_valid_i
);
    logic in_flight_q;
    int   fail_count = 0;

    // one request on the bus until its response
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight_q <= 1'b0;
        end else if (imem_req_i) begin
            in_flight_q <= 1'b1;
        end else if (imem_resp_valid_i) begin
            in_flight_q <= 1'b0;
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        !rst_n |=> (!imem_req_i && inst_valid_i == 2'b00))
        else begin
            fail_count++;
            $error("request or valid output active right after reset");
        end

    single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_i |-> !in_flight_q)
        else begin
            fail_count++;
            $error("second bus request before the response");
        end

    valid_thermometer: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid_i[1] |-> inst_valid_i[0])
        else begin
            fail_count++;
            $error("slot 1 valid without slot 0");
        end

    addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_i |-> (imem_addr_i[2:0] == 3'b000))
        else begin
            fail_count++;
            $error("bus address not 8-byte aligned");
        end

endmodule

bind frontend frontend_assert u_assert (
    .clk(clk),
    .rst_n(rst_n),
    .imem_req_i(imem_req_o),
    .imem_addr_i(imem_addr_o),
    .imem_resp_valid_i(imem_resp_valid_i),
    .inst_valid_i(inst_valid_o)
);

//--- test/frontend_tb.sv
`timescale 1ns/1ps
`include "frontend_params.svh"

module frontend_tb;
    import frontend_pkg::*;

    localparam int N_SEQ       = 200;
    localparam int N_RAND      = 200;
    localparam int N_REDIR     = 200;
    localparam int N_LOCK      = 100;
    localparam int CYCLE_LIMIT = 4 * (N_SEQ + N_RAND + N_REDIR + N_LOCK) * 6 + 200;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             imem_req_o;
    pc_t              imem_addr_o;
    logic             imem_resp_valid_i;
    logic [63:0]      imem_resp_data_i;
    logic             redirect_i;
    pc_t              redirect_pc_i;
    logic             wait_i;
    logic             int_i;
    logic             backend_stall_i;
    logic [1:0]       issue_num_i;
    logic [1:0]       inst_valid_o;
    pc_t [1:0]        inst_pc_o;
    inst_word_t [1:0] inst_word_o;
    reg_idx_t [1:0]   inst_rj_o;
    reg_idx_t [1:0]   inst_rk_o;
    reg_idx_t [1:0]   inst_rd_o;

    inst_word_t imem [512];
    string      test_name = "reset";
    pc_t        exp_pc = `FE_RESET_PC;
    int         pops_done = 0;
    int         cycles = 0;
    logic [4:0] class_seen = '0;
    logic       req_seen = 1'b0;
    pc_t        addr_seen;

    frontend uut (.*);

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_pc(input string field, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s %s expected %h actual %h",
                                test_name, field, exp, act));
        end
    endtask

    task automatic check_word(input string field, input inst_word_t exp, input inst_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s %s expected %h actual %h",
                                test_name, field, exp, act));
        end
    endtask

    task automatic check_reg(input string field, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s %s expected %0d actual %0d",
                                test_name, field, exp, act));
        end
    endtask

    // expected {rj, rk, rd} of one word
    function automatic logic [14:0] ref_decode(input inst_word_t w);
        logic [5:0] op;
        op = w[31:26];
        if (op == `FE_OP_ALU) begin
            return {w[9:5], w[14:10], w[4:0]};
        end else if (op >= `FE_OP_IMM_LO && op <= `FE_OP_IMM_HI) begin
            return {w[9:5], 5'd0, w[4:0]};
        end else if (op == `FE_OP_BL) begin
            return {5'd0, 5'd0, 5'd1};
        end else if (op >= `FE_OP_BR_LO && op <= `FE_OP_BR_HI) begin
            // rd field read as a source
            return {w[9:5], w[4:0], 5'd0};
        end
        return '0;
    endfunction

    function automatic int decode_class(input inst_word_t w);
        logic [5:0] op;
        op = w[31:26];
        if (op == `FE_OP_ALU) return 0;
        if (op >= `FE_OP_IMM_LO && op <= `FE_OP_IMM_HI) return 1;
        if (op == `FE_OP_BL) return 2;
        if (op >= `FE_OP_BR_LO && op <= `FE_OP_BR_HI) return 3;
        return 4;
    endfunction

    function automatic inst_word_t make_word();
        logic [5:0] op;
        case ($urandom_range(0, 5))
            0: op = `FE_OP_ALU;
            1: op = `FE_OP_IMM_LO + 6'($urandom_range(0, 14));
            2: op = `FE_OP_B;
            3: op = `FE_OP_BL;
            4: op = `FE_OP_BR_LO + 6'($urandom_range(0, 5));
            default: op = 6'd28 + 6'($urandom_range(0, 35));
        endcase
        return {op, 26'($urandom)};
    endfunction

    task automatic check_slot(input int s);
        inst_word_t  w;
        logic [14:0] regs;
        w = imem[exp_pc[10:2]];
        regs = ref_decode(w);
        check_pc("pc", exp_pc, inst_pc_o[s]);
        check_word("word", w, inst_word_o[s]);
        check_reg("rj", regs[14:10], inst_rj_o[s]);
        check_reg("rk", regs[9:5], inst_rk_o[s]);
        check_reg("rd", regs[4:0], inst_rd_o[s]);
        class_seen[decode_class(w)] = 1'b1;
        exp_pc = exp_pc + 32'd4;
        pops_done++;
    endtask

    task automatic drive_random(input bit with_redirect);
        issue_num_i = 2'($urandom_range(0, 2));
        backend_stall_i = ($urandom_range(0, 3) == 0);
        redirect_i = 1'b0;
        if (with_redirect && $urandom_range(0, 15) == 0) begin
            // odd-word targets about half the time
            redirect_i = 1'b1;
            redirect_pc_i = `FE_RESET_PC + pc_t'($urandom_range(0, 511) * 4);
        end
    endtask

    task automatic run_phase(input string name, input int count, input bit rand_mode,
                             input bit with_redirect);
        int target;
        test_name = name;
        target = pops_done + count;
        while (pops_done < target) begin
            @(posedge clk);
            #1;
            if (rand_mode) begin
                drive_random(with_redirect);
            end else begin
                issue_num_i = 2'd2;
                backend_stall_i = 1'b0;
                redirect_i = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        redirect_i = 1'b0;
    endtask

    // bus sampled and pops checked mid-cycle, where everything is settled
    always @(negedge clk) begin
        int slots;
        req_seen = imem_req_o;
        addr_seen = imem_addr_o;
        if (rst_n && redirect_i) begin
            exp_pc = redirect_pc_i;
        end else if (rst_n && !backend_stall_i) begin
            slots = inst_valid_o[1] ? 2 : int'(inst_valid_o[0]);
            if (int'(issue_num_i) < slots) begin
                slots = int'(issue_num_i);
            end
            for (int k = 0; k < slots; k++) begin
                check_slot(k);
            end
        end
    end

    // memory model, one pair per request after 1 to 4 cycles
    initial begin
        int         wait_left;
        logic       busy;
        pc_t        addr;
        logic [8:0] widx;
        imem_resp_valid_i = 1'b0;
        imem_resp_data_i = '0;
        busy = 1'b0;
        wait_left = 0;
        addr = '0;
        forever begin
            @(posedge clk);
            #1;
            imem_resp_valid_i = 1'b0;
            if (!rst_n) begin
                busy = 1'b0;
            end else begin
                if (busy) begin
                    wait_left--;
                    if (wait_left == 0) begin
                        widx = addr[10:2];
                        imem_resp_valid_i = 1'b1;
                        imem_resp_data_i = {imem[widx + 9'd1], imem[widx]};
                        busy = 1'b0;
                    end
                end
                if (req_seen) begin
                    if (busy) begin
                        abort_run("memory got a second request before answering the first");
                    end
                    busy = 1'b1;
                    wait_left = $urandom_range(1, 4);
                    addr = addr_seen;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout, run not finished after %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        int i;
        void'($urandom(32'hc8f73a48));
        rst_n = 1'b0;
        redirect_i = 1'b0;
        redirect_pc_i = '0;
        wait_i = 1'b0;
        int_i = 1'b0;
        backend_stall_i = 1'b0;
        issue_num_i = 2'd0;
        for (i = 0; i < 512; i++) begin
            imem[i] = make_word();
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        run_phase("sequential", N_SEQ, 1'b0, 1'b0);
        run_phase("random_issue", N_RAND, 1'b1, 1'b0);
        run_phase("redirect", N_REDIR, 1'b1, 1'b1);

        test_name = "idle_lock";
        issue_num_i = 2'd2;
        backend_stall_i = 1'b0;
        wait_i = 1'b1;
        @(posedge clk);
        #1;
        wait_i = 1'b0;
        // a request issued in the wait cycle still shows one cycle later
        @(posedge clk);
        #1;
        repeat (40) begin
            @(negedge clk);
            if (imem_req_o) begin
                abort_run("bus request issued while the idle lock was set");
            end
        end
        if (inst_valid_o != 2'b00) begin
            abort_run("queues did not drain while the idle lock was set");
        end
        @(posedge clk);
        #1;
        int_i = 1'b1;
        @(posedge clk);
        #1;
        int_i = 1'b0;
        run_phase("lock_resume", N_LOCK, 1'b0, 1'b0);

        if (uut.u_assert.fail_count != 0) begin
            abort_run("one or more concurrent assertions failed");
        end else if (class_seen != 5'b11111) begin
            abort_run($sformatf("not every decode class was checked, seen %b", class_seen));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- sources.f
+incdir+include
src/frontend_pkg.sv
src/pc_gen.sv
src/fetch_unit.sv
src/multi_channel_fifo.sv
src/inst_decoder.sv
src/frontend.sv
test/frontend_assert.sv
test/frontend_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module frontend_tb \
    -o frontend_sim > build.log 2>&1 \
    && ./obj_dir/frontend_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
